//--- rtl/udp_noc_pkg.sv
`default_nettype none

package udp_noc_pkg;

    ////////////////////////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////////////////////////
    localparam int NOC_DATA_W   = 128;
    localparam int NODE_ID_W    = 16;
    localparam int MSG_LEN_W    = 8;
    localparam int IP_ADDR_W    = 32;
    localparam int PORT_W       = 16;
    localparam int UDP_LEN_W    = 16;
    localparam int NUM_BLOCKS_W = 8;

    // UDP length grows by one block in the reply.
    localparam logic [UDP_LEN_W-1:0] BLOCK_BYTES = 16;

    localparam int HDR_PAD_W  = NOC_DATA_W - 2 * NODE_ID_W - MSG_LEN_W;
    localparam int META_PAD_W = NOC_DATA_W - 2 * IP_ADDR_W - 2 * PORT_W - UDP_LEN_W;
    localparam int REQ_PAD_W  = NOC_DATA_W - NUM_BLOCKS_W;

    ////////////////////////////////////////////////////////////
    // Flit formats, most significant field first
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [NODE_ID_W-1:0] dst_id;
        logic [NODE_ID_W-1:0] src_id;
        logic [MSG_LEN_W-1:0] msg_len;
        logic [HDR_PAD_W-1:0] padding;
    } noc_hdr_flit;

    typedef struct packed {
        logic [IP_ADDR_W-1:0]  src_ip;
        logic [IP_ADDR_W-1:0]  dst_ip;
        logic [PORT_W-1:0]     src_port;
        logic [PORT_W-1:0]     dst_port;
        logic [UDP_LEN_W-1:0]  data_length;
        logic [META_PAD_W-1:0] padding;
    } udp_meta_flit;

    typedef struct packed {
        logic [NUM_BLOCKS_W-1:0] num_req_blocks;
        logic [REQ_PAD_W-1:0]    padding;
    } req_flit;

endpackage

`default_nettype wire

//--- rtl/rs_encode_pkg.sv
`default_nettype none

package rs_encode_pkg;

    ////////////////////////////////////////////////////////////
    // Input FSM states
    ////////////////////////////////////////////////////////////
    // One state per flit kind of an incoming message.
    typedef enum logic [1:0] {
        ST_HDR,
        ST_META,
        ST_REQ,
        ST_DATA
    } in_state_e;

    ////////////////////////////////////////////////////////////
    // Reply flit select
    ////////////////////////////////////////////////////////////
    // Kind of reply flit to form in the output stage.
    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_HDR,
        SEL_META,
        SEL_REQ,
        SEL_DATA,
        SEL_PARITY
    } out_sel_e;

endpackage

`default_nettype wire

//--- rtl/udp_rs_encode_in_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module udp_rs_encode_in_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_val,
    input  logic                    last_flit,
    output logic                    store_hdr,
    output logic                    store_meta,
    output logic                    store_req,
    output logic                    incr_flits,
    output logic                    last_data,
    output rs_encode_pkg::out_sel_e flit_sel
);

    rs_encode_pkg::in_state_e state_reg;
    rs_encode_pkg::in_state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= rs_encode_pkg::ST_HDR;
        end else begin
            state_reg <= state_next;
        end
    end

    // Strobes are only raised on a valid flit.
    always_comb begin
        store_hdr  = 1'b0;
        store_meta = 1'b0;
        store_req  = 1'b0;
        incr_flits = 1'b0;
        last_data  = 1'b0;
        flit_sel   = rs_encode_pkg::SEL_NONE;
        state_next = state_reg;

        if (in_val) begin
            case (state_reg)
                rs_encode_pkg::ST_HDR: begin
                    store_hdr  = 1'b1;
                    flit_sel   = rs_encode_pkg::SEL_HDR;
                    state_next = rs_encode_pkg::ST_META;
                end
                rs_encode_pkg::ST_META: begin
                    store_meta = 1'b1;
                    incr_flits = 1'b1;
                    flit_sel   = rs_encode_pkg::SEL_META;
                    state_next = rs_encode_pkg::ST_REQ;
                end
                rs_encode_pkg::ST_REQ: begin
                    store_req  = 1'b1;
                    incr_flits = 1'b1;
                    flit_sel   = rs_encode_pkg::SEL_REQ;
                    state_next = rs_encode_pkg::ST_DATA;
                end
                rs_encode_pkg::ST_DATA: begin
                    incr_flits = 1'b1;
                    flit_sel   = rs_encode_pkg::SEL_DATA;
                    // Last data block closes the message.
                    if (last_flit) begin
                        last_data  = 1'b1;
                        state_next = rs_encode_pkg::ST_HDR;
                    end
                end
                default: begin
                    state_next = rs_encode_pkg::ST_HDR;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/udp_rs_encode_in_datap.sv
`timescale 1ns/10ps
`default_nettype none

module udp_rs_encode_in_datap (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [udp_noc_pkg::NOC_DATA_W-1:0]   in_data,
    input  logic                                 store_hdr,
    input  logic                                 store_meta,
    input  logic                                 store_req,
    input  logic                                 incr_flits,
    output logic [udp_noc_pkg::MSG_LEN_W-1:0]    msg_len,
    output logic [udp_noc_pkg::IP_ADDR_W-1:0]    src_ip,
    output logic [udp_noc_pkg::IP_ADDR_W-1:0]    dst_ip,
    output logic [udp_noc_pkg::PORT_W-1:0]       src_port,
    output logic [udp_noc_pkg::PORT_W-1:0]       dst_port,
    output logic [udp_noc_pkg::UDP_LEN_W-1:0]    data_len,
    output logic [udp_noc_pkg::NUM_BLOCKS_W-1:0] num_blocks,
    output logic                                 last_flit
);

    udp_noc_pkg::noc_hdr_flit  hdr_cast;
    udp_noc_pkg::udp_meta_flit meta_cast;
    udp_noc_pkg::req_flit      req_cast;

    logic [udp_noc_pkg::MSG_LEN_W-1:0]    num_flits_reg;
    logic [udp_noc_pkg::MSG_LEN_W-1:0]    num_flits_next;
    logic [udp_noc_pkg::MSG_LEN_W-1:0]    flits_cnt_reg;
    logic [udp_noc_pkg::MSG_LEN_W-1:0]    flits_cnt_next;
    logic [udp_noc_pkg::NUM_BLOCKS_W-1:0] num_blocks_reg;
    logic [udp_noc_pkg::NUM_BLOCKS_W-1:0] num_blocks_next;

    logic [udp_noc_pkg::IP_ADDR_W-1:0] src_ip_reg;
    logic [udp_noc_pkg::IP_ADDR_W-1:0] dst_ip_reg;
    logic [udp_noc_pkg::PORT_W-1:0]    src_port_reg;
    logic [udp_noc_pkg::PORT_W-1:0]    dst_port_reg;
    logic [udp_noc_pkg::UDP_LEN_W-1:0] data_len_reg;

    assign hdr_cast  = in_data;
    assign meta_cast = in_data;
    assign req_cast  = in_data;

    ////////////////////////////////////////////////////////////
    // Hold-or-load field capture
    ////////////////////////////////////////////////////////////
    assign num_flits_next  = store_hdr ? hdr_cast.msg_len : num_flits_reg;
    assign num_blocks_next = store_req ? req_cast.num_req_blocks : num_blocks_reg;

    assign src_ip   = store_meta ? meta_cast.src_ip      : src_ip_reg;
    assign dst_ip   = store_meta ? meta_cast.dst_ip      : dst_ip_reg;
    assign src_port = store_meta ? meta_cast.src_port    : src_port_reg;
    assign dst_port = store_meta ? meta_cast.dst_port    : dst_port_reg;
    assign data_len = store_meta ? meta_cast.data_length : data_len_reg;

    // Fields are visible in the cycle their flit arrives.
    assign msg_len    = num_flits_next;
    assign num_blocks = num_blocks_next;

    always_ff @(posedge clk) begin
        src_ip_reg     <= src_ip;
        dst_ip_reg     <= dst_ip;
        src_port_reg   <= src_port;
        dst_port_reg   <= dst_port;
        data_len_reg   <= data_len;
        num_blocks_reg <= num_blocks_next;
    end

    ////////////////////////////////////////////////////////////
    // Flit counter
    ////////////////////////////////////////////////////////////
    // Counts flits after the header, so the last one sits at msg_len - 1.
    assign flits_cnt_next = store_hdr  ? '0 :
                            incr_flits ? flits_cnt_reg + 1'b1 :
                                         flits_cnt_reg;

    assign last_flit = (flits_cnt_reg == (num_flits_reg - 1'b1));

    always_ff @(posedge clk) begin
        if (rst) begin
            num_flits_reg <= '0;
            flits_cnt_reg <= '0;
        end else begin
            num_flits_reg <= num_flits_next;
            flits_cnt_reg <= flits_cnt_next;
        end
    end

endmodule

`default_nettype wire

//--- rtl/parity_block_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module parity_block_encoder (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [udp_noc_pkg::NOC_DATA_W-1:0] data,
    input  logic                               data_val,
    input  logic                               last,
    output logic [udp_noc_pkg::NOC_DATA_W-1:0] parity,
    output logic                               parity_val
);

    // Single check symbol, so the parity block is the XOR of all blocks.
    logic [udp_noc_pkg::NOC_DATA_W-1:0] acc_reg;
    logic [udp_noc_pkg::NOC_DATA_W-1:0] acc_next;

    assign acc_next = data_val ? (acc_reg ^ data) : acc_reg;

    ////////////////////////////////////////////////////////////
    // Accumulator
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_reg <= '0;
        end else if (last) begin
            // Start clean for the next message.
            acc_reg <= '0;
        end else begin
            acc_reg <= acc_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // Parity output
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (last) begin
            parity <= acc_next;
        end
    end

    // One-cycle pulse after the last block.
    always_ff @(posedge clk) begin
        if (rst) begin
            parity_val <= 1'b0;
        end else begin
            parity_val <= last;
        end
    end

endmodule

`default_nettype wire

//--- rtl/udp_rs_encode_out_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module udp_rs_encode_out_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [udp_noc_pkg::NOC_DATA_W-1:0]   in_data,
    input  rs_encode_pkg::out_sel_e              flit_sel,
    input  logic [udp_noc_pkg::MSG_LEN_W-1:0]    msg_len,
    input  logic [udp_noc_pkg::IP_ADDR_W-1:0]    src_ip,
    input  logic [udp_noc_pkg::IP_ADDR_W-1:0]    dst_ip,
    input  logic [udp_noc_pkg::PORT_W-1:0]       src_port,
    input  logic [udp_noc_pkg::PORT_W-1:0]       dst_port,
    input  logic [udp_noc_pkg::UDP_LEN_W-1:0]    data_len,
    input  logic [udp_noc_pkg::NUM_BLOCKS_W-1:0] num_blocks,
    input  logic [udp_noc_pkg::NOC_DATA_W-1:0]   parity,
    input  logic                                 parity_val,
    output logic [udp_noc_pkg::NOC_DATA_W-1:0]   out_data,
    output logic                                 out_val
);

    udp_noc_pkg::noc_hdr_flit  hdr_in;
    udp_noc_pkg::udp_meta_flit meta_in;
    udp_noc_pkg::req_flit      req_in;
    udp_noc_pkg::noc_hdr_flit  hdr_out;
    udp_noc_pkg::udp_meta_flit meta_out;
    udp_noc_pkg::req_flit      req_out;

    logic [udp_noc_pkg::NOC_DATA_W-1:0] reply_next;

    assign hdr_in  = in_data;
    assign meta_in = in_data;
    assign req_in  = in_data;

    ////////////////////////////////////////////////////////////
    // Reply flit formation
    ////////////////////////////////////////////////////////////
    // Header goes back to the sender with room for the parity flit.
    assign hdr_out.dst_id  = hdr_in.src_id;
    assign hdr_out.src_id  = hdr_in.dst_id;
    assign hdr_out.msg_len = msg_len + 1'b1;
    assign hdr_out.padding = hdr_in.padding;

    assign meta_out.src_ip      = dst_ip;
    assign meta_out.dst_ip      = src_ip;
    assign meta_out.src_port    = dst_port;
    assign meta_out.dst_port    = src_port;
    assign meta_out.data_length = data_len + udp_noc_pkg::BLOCK_BYTES;
    assign meta_out.padding     = meta_in.padding;

    assign req_out.num_req_blocks = num_blocks + 1'b1;
    assign req_out.padding        = req_in.padding;

    // Parity only shows up in the idle cycle after a message.
    always_comb begin
        if (parity_val) begin
            reply_next = parity;
        end else begin
            case (flit_sel)
                rs_encode_pkg::SEL_HDR:  reply_next = hdr_out;
                rs_encode_pkg::SEL_META: reply_next = meta_out;
                rs_encode_pkg::SEL_REQ:  reply_next = req_out;
                default:                 reply_next = in_data;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        out_data <= reply_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_val <= 1'b0;
        end else begin
            out_val <= parity_val || (flit_sel != rs_encode_pkg::SEL_NONE);
        end
    end

endmodule

`default_nettype wire

//--- rtl/udp_rs_encode_top.sv
`timescale 1ns/10ps
`default_nettype none

module udp_rs_encode_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [udp_noc_pkg::NOC_DATA_W-1:0] in_data,
    input  logic                               in_val,
    output logic [udp_noc_pkg::NOC_DATA_W-1:0] out_data,
    output logic                               out_val
);

    logic                                 store_hdr;
    logic                                 store_meta;
    logic                                 store_req;
    logic                                 incr_flits;
    logic                                 last_data;
    logic                                 last_flit;
    logic                                 data_strobe;
    rs_encode_pkg::out_sel_e              flit_sel;
    logic [udp_noc_pkg::MSG_LEN_W-1:0]    msg_len;
    logic [udp_noc_pkg::IP_ADDR_W-1:0]    src_ip;
    logic [udp_noc_pkg::IP_ADDR_W-1:0]    dst_ip;
    logic [udp_noc_pkg::PORT_W-1:0]       src_port;
    logic [udp_noc_pkg::PORT_W-1:0]       dst_port;
    logic [udp_noc_pkg::UDP_LEN_W-1:0]    data_len;
    logic [udp_noc_pkg::NUM_BLOCKS_W-1:0] num_blocks;
    logic [udp_noc_pkg::NOC_DATA_W-1:0]   parity;
    logic                                 parity_val;

    // Only data blocks feed the encoder.
    assign data_strobe = incr_flits && (flit_sel == rs_encode_pkg::SEL_DATA);

    udp_rs_encode_in_ctrl in_ctrl (
        .clk        (clk),
        .rst        (rst),
        .in_val     (in_val),
        .last_flit  (last_flit),
        .store_hdr  (store_hdr),
        .store_meta (store_meta),
        .store_req  (store_req),
        .incr_flits (incr_flits),
        .last_data  (last_data),
        .flit_sel   (flit_sel)
    );

    udp_rs_encode_in_datap in_datap (
        .clk        (clk),
        .rst        (rst),
        .in_data    (in_data),
        .store_hdr  (store_hdr),
        .store_meta (store_meta),
        .store_req  (store_req),
        .incr_flits (incr_flits),
        .msg_len    (msg_len),
        .src_ip     (src_ip),
        .dst_ip     (dst_ip),
        .src_port   (src_port),
        .dst_port   (dst_port),
        .data_len   (data_len),
        .num_blocks (num_blocks),
        .last_flit  (last_flit)
    );

    parity_block_encoder encoder (
        .clk        (clk),
        .rst        (rst),
        .data       (in_data),
        .data_val   (data_strobe),
        .last       (last_data),
        .parity     (parity),
        .parity_val (parity_val)
    );

    udp_rs_encode_out_ctrl out_ctrl (
        .clk        (clk),
        .rst        (rst),
        .in_data    (in_data),
        .flit_sel   (flit_sel),
        .msg_len    (msg_len),
        .src_ip     (src_ip),
        .dst_ip     (dst_ip),
        .src_port   (src_port),
        .dst_port   (dst_port),
        .data_len   (data_len),
        .num_blocks (num_blocks),
        .parity     (parity),
        .parity_val (parity_val),
        .out_data   (out_data),
        .out_val    (out_val)
    );

endmodule

`default_nettype wire

//--- verification/udp_rs_encode_checker.sv
`timescale 1ns/10ps
`default_nettype none

module udp_rs_encode_checker (
    input logic clk,
    input logic rst,
    input logic in_val,
    input logic last_data,
    input logic parity_val,
    input logic out_val
);

    int fail_count;

    initial begin
        fail_count = 0;
    end

    // Reply stream stays quiet while in reset.
    out_val_in_reset: assert property (@(posedge clk) rst |=> !out_val)
        else begin
            fail_count++;
            $error("out_val high during reset");
        end

    parity_after_last: assert property (@(posedge clk) disable iff (rst)
        last_data |=> parity_val)
        else begin
            fail_count++;
            $error("parity_val missing one cycle after last_data");
        end

    parity_only_after_last: assert property (@(posedge clk) disable iff (rst)
        parity_val |-> $past(last_data))
        else begin
            fail_count++;
            $error("parity_val without last_data one cycle before");
        end

    // Sender must leave an idle cycle after each message.
    idle_gap_after_last: assert property (@(posedge clk) disable iff (rst)
        last_data |=> !in_val)
        else begin
            fail_count++;
            $error("in_val high in the cycle after last_data");
        end

endmodule

bind udp_rs_encode_top udp_rs_encode_checker protocol_checks (
    .clk        (clk),
    .rst        (rst),
    .in_val     (in_val),
    .last_data  (last_data),
    .parity_val (parity_val),
    .out_val    (out_val)
);

`default_nettype wire

//--- verification/udp_rs_encode_tb.sv
`timescale 1ns/10ps
`default_nettype none

module udp_rs_encode_tb;

    localparam int CLK_PERIOD     = 40;
    // Flits driven over all tests.
    localparam int TEST_FLITS     = 56;
    localparam int TIMEOUT_CYCLES = TEST_FLITS * 4 + 64;

    logic                               clk = 1'b0;
    logic                               rst;
    logic [udp_noc_pkg::NOC_DATA_W-1:0] in_data;
    logic                               in_val;
    logic [udp_noc_pkg::NOC_DATA_W-1:0] out_data;
    logic                               out_val;
    int                                 cycle = 0;

    // Expected reply flits and the cycle each one is due in.
    rs_encode_pkg::out_sel_e            exp_kind[$];
    logic [udp_noc_pkg::NOC_DATA_W-1:0] exp_data[$];
    int                                 exp_cycle[$];

    udp_rs_encode_top UUT (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_data),
        .in_val   (in_val),
        .out_data (out_data),
        .out_val  (out_val)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_hdr(string name, udp_noc_pkg::noc_hdr_flit exp,
                             udp_noc_pkg::noc_hdr_flit act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_meta(string name, udp_noc_pkg::udp_meta_flit exp,
                              udp_noc_pkg::udp_meta_flit act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_req(string name, udp_noc_pkg::req_flit exp,
                             udp_noc_pkg::req_flit act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_block(string name, logic [udp_noc_pkg::NOC_DATA_W-1:0] exp,
                               logic [udp_noc_pkg::NOC_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_cycle(string name, int exp, int act);
        if (act != exp) begin
            $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_reply_flit();
        rs_encode_pkg::out_sel_e            kind;
        logic [udp_noc_pkg::NOC_DATA_W-1:0] exp;
        int                                 due;
        kind = exp_kind.pop_front();
        exp  = exp_data.pop_front();
        due  = exp_cycle.pop_front();
        check_cycle("out_val cycle", due, cycle);
        case (kind)
            rs_encode_pkg::SEL_HDR:    check_hdr("out_data header", exp, out_data);
            rs_encode_pkg::SEL_META:   check_meta("out_data metadata", exp, out_data);
            rs_encode_pkg::SEL_REQ:    check_req("out_data request", exp, out_data);
            rs_encode_pkg::SEL_PARITY: check_block("out_data parity", exp, out_data);
            default:                   check_block("out_data block", exp, out_data);
        endcase
    endtask

    // Outputs are registered, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (UUT.protocol_checks.fail_count != 0) begin
            $display("Protocol assertion failed in the bound checker at %0t", $time);
            abort_run();
        end else if (out_val === 1'b1) begin
            if (exp_data.size() == 0) begin
                $display("Unexpected out_val at %0t with no reply flit pending", $time);
                abort_run();
            end else begin
                check_reply_flit();
            end
        end else if (out_val !== 1'b0) begin
            $display("out_val is unknown at %0t", $time);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [udp_noc_pkg::NOC_DATA_W-1:0] random_flit();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic drive_idle(int n);
        repeat (n) begin
            @(posedge clk);
            in_val <= 1'b0;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst    <= 1'b1;
        in_val <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic send_flit(logic [udp_noc_pkg::NOC_DATA_W-1:0] flit,
                             rs_encode_pkg::out_sel_e kind,
                             logic [udp_noc_pkg::NOC_DATA_W-1:0] reply,
                             int max_gap, output int due);
        if (max_gap > 0) begin
            drive_idle($urandom_range(max_gap, 0));
        end
        @(posedge clk);
        in_data <= flit;
        in_val  <= 1'b1;
        // Counter still holds the previous edge here.
        due = cycle + 2;
        exp_kind.push_back(kind);
        exp_data.push_back(reply);
        exp_cycle.push_back(due);
    endtask

    // Drives the first n_drive blocks; a full message also gets its parity.
    task automatic send_message(logic [udp_noc_pkg::NUM_BLOCKS_W-1:0] n_blocks,
                                int n_drive, int max_gap);
        udp_noc_pkg::noc_hdr_flit           hdr;
        udp_noc_pkg::noc_hdr_flit           hdr_exp;
        udp_noc_pkg::udp_meta_flit          meta;
        udp_noc_pkg::udp_meta_flit          meta_exp;
        udp_noc_pkg::req_flit               req;
        udp_noc_pkg::req_flit               req_exp;
        logic [udp_noc_pkg::NOC_DATA_W-1:0] block;
        logic [udp_noc_pkg::NOC_DATA_W-1:0] parity_exp;
        int                                 due;
        int                                 i;
        hdr             = random_flit();
        hdr.msg_len     = n_blocks + 8'd2;
        hdr_exp         = hdr;
        hdr_exp.dst_id  = hdr.src_id;
        hdr_exp.src_id  = hdr.dst_id;
        hdr_exp.msg_len = hdr.msg_len + 8'd1;
        send_flit(hdr, rs_encode_pkg::SEL_HDR, hdr_exp, max_gap, due);

        meta                 = random_flit();
        meta.data_length     = n_blocks * udp_noc_pkg::BLOCK_BYTES;
        meta_exp             = meta;
        meta_exp.src_ip      = meta.dst_ip;
        meta_exp.dst_ip      = meta.src_ip;
        meta_exp.src_port    = meta.dst_port;
        meta_exp.dst_port    = meta.src_port;
        meta_exp.data_length = meta.data_length + udp_noc_pkg::BLOCK_BYTES;
        send_flit(meta, rs_encode_pkg::SEL_META, meta_exp, max_gap, due);

        req                    = random_flit();
        req.num_req_blocks     = n_blocks;
        req_exp                = req;
        req_exp.num_req_blocks = n_blocks + 8'd1;
        send_flit(req, rs_encode_pkg::SEL_REQ, req_exp, max_gap, due);

        parity_exp = '0;
        for (i = 0; i < n_drive; i++) begin
            block      = random_flit();
            parity_exp = parity_exp ^ block;
            send_flit(block, rs_encode_pkg::SEL_DATA, block, max_gap, due);
        end
        if (n_drive == int'(n_blocks)) begin
            exp_kind.push_back(rs_encode_pkg::SEL_PARITY);
            exp_data.push_back(parity_exp);
            exp_cycle.push_back(due + 1);
            drive_idle(1);
        end
    endtask

    task automatic wait_drain(int max_cycles);
        int n;
        n = 0;
        while (exp_data.size() != 0 && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (exp_data.size() != 0) begin
            $display("Reply stream stalled with %0d flits still due", exp_data.size());
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_single_block();
        send_message(8'd1, 1, 0);
        wait_drain(8);
    endtask

    task automatic test_eight_blocks();
        send_message(8'd8, 8, 0);
        wait_drain(8);
    endtask

    // Every reply flit is checked against its due cycle.
    task automatic test_latency();
        send_message(8'd3, 3, 0);
        wait_drain(8);
    endtask

    task automatic test_back_to_back();
        send_message(8'd4, 4, 0);
        send_message(8'd5, 5, 0);
        wait_drain(8);
    endtask

    task automatic test_idle_gaps();
        send_message(8'd6, 6, 3);
        wait_drain(8);
    endtask

    task automatic test_reset_mid_message();
        send_message(8'd5, 2, 0);
        apply_reset();
        wait_drain(8);
        send_message(8'd3, 3, 0);
        wait_drain(8);
    endtask

    initial begin
        rst     <= 1'b1;
        in_val  <= 1'b0;
        in_data <= '0;
        void'($urandom(57));
        apply_reset();
        test_single_block();
        test_eight_blocks();
        test_latency();
        test_back_to_back();
        test_idle_gaps();
        test_reset_mid_message();
        drive_idle(4);
        if (UUT.protocol_checks.fail_count == 0 && exp_data.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("Run ended with assertion failures or reply flits still due");
            abort_run();
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        abort_run();
    end

endmodule

`default_nettype wire

//--- list.f
rtl/udp_noc_pkg.sv
rtl/rs_encode_pkg.sv
rtl/udp_rs_encode_in_ctrl.sv
rtl/udp_rs_encode_in_datap.sv
rtl/parity_block_encoder.sv
rtl/udp_rs_encode_out_ctrl.sv
rtl/udp_rs_encode_top.sv
verification/udp_rs_encode_checker.sv
verification/udp_rs_encode_tb.sv

//--- Makefile
TOP = udp_rs_encode_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
